// File: Makefile
# Verilator flow for the simulated DDR memory subsystem
TOP := simddr_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f simddr.f

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f simddr.f -o simddr_sim
	./obj_dir/simddr_sim 2>&1 | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: simddr.f
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/ddr_ctrl_pkg.sv
verilog/ddr_req_if.sv
verilog/port_arbiter.sv
verilog/ddr_timing_model.sv
verilog/resp_router.sv
verilog/simddr_top.sv
tests/simddr_assertions.sv
tests/simddr_tb.sv

// File: tests/simddr_assertions.sv
`timescale 1ns/1ps

// protocol checks, bound into the arbiter and the router
module simddr_assertions (
    input logic clk,
    input logic rst_n,
    input logic data_req,    // port strobes as the arbiter sees them
    input logic line_req,
    input logic pend_data,   // arbiter slot occupied
    input logic pend_line,
    input logic cmd_valid,
    input logic model_idle,
    input logic data_done,   // router outputs
    input logic line_done
);
    // done strobes last a single cycle
    a_data_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        data_done |=> !data_done)
        else $error("data_done high for more than one cycle");

    a_line_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        line_done |=> !line_done)
        else $error("line_done high for more than one cycle");

    // the model takes every issued command and leaves idle
    a_cmd_accepted: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |=> !model_idle)
        else $error("model still idle in the cycle after cmd_valid");

    // one outstanding request per port
    a_data_no_restrobe: assert property (@(posedge clk) disable iff (!rst_n)
        data_req |-> !pend_data)
        else $error("data_req while a data port request is pending");

    a_line_no_restrobe: assert property (@(posedge clk) disable iff (!rst_n)
        line_req |-> !pend_line)
        else $error("line_req while a line port request is pending");
endmodule

// File: tests/simddr_tb.sv
`timescale 1ns/1ps
`include "simddr_params.svh"

module simddr_tb;
    localparam int REC_WORDS   = 3 + `DDR_BURST_WORDS;  // op, addr, mask, then data words
    localparam int MAX_RECS    = 32;
    localparam int TIMEOUT_CYC = 400;                    // above both latencies back to back
    localparam int SINGLE_LAT  = `DDR_SINGLE_CYCLES + 2; // strobe to done
    localparam int BURST_LAT   = `DDR_BURST_CYCLES + 2;
    // line port waits out the data access and then runs its own burst
    localparam int PAIR_LAT    = `DDR_SINGLE_CYCLES + `DDR_BURST_CYCLES + 3;

    logic                  clk;
    logic                  rst_n;
    logic                  data_req;
    logic                  data_we;
    mem_types_pkg::addr_t  data_addr;
    mem_types_pkg::mask_t  data_mask;
    mem_types_pkg::word_t  data_wdata;
    logic                  data_done;
    mem_types_pkg::word_t  data_rdata;
    logic                  line_req;
    logic                  line_we;
    mem_types_pkg::addr_t  line_addr;
    mem_types_pkg::line_t  line_wdata;
    logic                  line_done;
    mem_types_pkg::line_t  line_rdata;

    logic [`DDR_WORD_BITS-1:0] tdata [0:REC_WORDS*MAX_RECS-1];  // records from the data file
    logic [31:0]           lfsr;       // gap generator state
    mem_types_pkg::word_t  last_rd;    // data_rdata must keep this across writes
    mem_types_pkg::line_t  last_line;
    int                    rec;

    simddr_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_mask  (data_mask),
        .data_wdata (data_wdata),
        .data_done  (data_done),
        .data_rdata (data_rdata),
        .line_req   (line_req),
        .line_we    (line_we),
        .line_addr  (line_addr),
        .line_wdata (line_wdata),
        .line_done  (line_done),
        .line_rdata (line_rdata)
    );

    bind port_arbiter simddr_assertions i_arb_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .line_req   (line_req),
        .pend_data  (pend_data),
        .pend_line  (pend_line),
        .cmd_valid  (req.cmd_valid),
        .model_idle (req.model_idle),
        .data_done  (1'b0),
        .line_done  (1'b0)
    );

    bind resp_router simddr_assertions i_rtr_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (1'b0),
        .line_req   (1'b0),
        .pend_data  (1'b0),
        .pend_line  (1'b0),
        .cmd_valid  (1'b0),
        .model_idle (1'b1),
        .data_done  (data_done),
        .line_done  (line_done)
    );

    always #20 clk = ~clk;  // 40 ns period

    // right-shifting form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(string name, mem_types_pkg::line_t got, mem_types_pkg::line_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %0h expected %0h", name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // 0..7 idle cycles from three LFSR bits
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 3; i++) begin
            gap = (gap << 1) | int'(lfsr[0]);
            lfsr = galois_step(lfsr);
        end
        repeat (gap) @(negedge clk);
    endtask

    task automatic drive_data(logic we, mem_types_pkg::addr_t a, mem_types_pkg::mask_t m,
                              mem_types_pkg::word_t d);
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = a;
        data_mask  = m;
        data_wdata = d;
    endtask

    task automatic drive_line(logic we, mem_types_pkg::addr_t a, mem_types_pkg::line_t d);
        line_req   = 1'b1;
        line_we    = we;
        line_addr  = a;
        line_wdata = d;
    endtask

    // counts falling edges from the strobe until the done strobe shows up
    task automatic wait_done(logic line_port, output int cycles);
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            data_req = 1'b0;  // strobes last one cycle
            line_req = 1'b0;
            cycles++;
            seen = line_port ? line_done : data_done;
            if (!seen && cycles >= TIMEOUT_CYC)
                report_failure(line_port ? "timeout waiting for line_done"
                                         : "timeout waiting for data_done");
        end
    endtask

    task automatic wait_both(output int d_cyc, output int l_cyc);
        int cycles;
        cycles = 0;
        d_cyc = 0;
        l_cyc = 0;
        while (d_cyc == 0 || l_cyc == 0) begin
            @(negedge clk);
            data_req = 1'b0;
            line_req = 1'b0;
            cycles++;
            if (data_done && d_cyc == 0)
                d_cyc = cycles;
            if (line_done && l_cyc == 0)
                l_cyc = cycles;
            if ((d_cyc == 0 || l_cyc == 0) && cycles >= TIMEOUT_CYC)
                report_failure("timeout waiting for data_done and line_done");
        end
    endtask

    task automatic run_record(int base);
        logic [`DDR_WORD_BITS-1:0] op;
        mem_types_pkg::addr_t      a;
        mem_types_pkg::mask_t      m;
        mem_types_pkg::line_t      ln;
        mem_types_pkg::word_t      w0;
        int                        cyc;
        int                        lcyc;
        op = tdata[base];
        a  = tdata[base+1][`DDR_ADDR_BITS-1:0];
        m  = tdata[base+2];
        for (int k = 0; k < `DDR_BURST_WORDS; k++)
            ln[k*`DDR_WORD_BITS +: `DDR_WORD_BITS] = tdata[base+3+k];
        w0 = ln[`DDR_WORD_BITS-1:0];  // single ops use word 0 only
        case (op)
            64'h0: begin  // single read
                drive_data(1'b0, a, m, w0);
                wait_done(1'b0, cyc);
                check_value("data_done latency", mem_types_pkg::line_t'(cyc),
                            mem_types_pkg::line_t'(SINGLE_LAT));
                check_value("data_rdata", mem_types_pkg::line_t'(data_rdata),
                            mem_types_pkg::line_t'(w0));
                last_rd = w0;
            end
            64'h1: begin  // single masked write that must not touch data_rdata
                drive_data(1'b1, a, m, w0);
                wait_done(1'b0, cyc);
                check_value("data_done latency", mem_types_pkg::line_t'(cyc),
                            mem_types_pkg::line_t'(SINGLE_LAT));
                check_value("data_rdata", mem_types_pkg::line_t'(data_rdata),
                            mem_types_pkg::line_t'(last_rd));
            end
            64'h2: begin  // burst read
                drive_line(1'b0, a, ln);
                wait_done(1'b1, cyc);
                check_value("line_done latency", mem_types_pkg::line_t'(cyc),
                            mem_types_pkg::line_t'(BURST_LAT));
                check_value("line_rdata", line_rdata, ln);
                last_line = ln;
            end
            64'h3: begin  // burst write
                drive_line(1'b1, a, ln);
                wait_done(1'b1, cyc);
                check_value("line_done latency", mem_types_pkg::line_t'(cyc),
                            mem_types_pkg::line_t'(BURST_LAT));
                check_value("line_rdata", line_rdata, last_line);
            end
            64'h4: begin  // both ports in the same cycle with the data port first
                drive_data(1'b0, a, m, w0);
                drive_line(1'b0, a, ln);
                wait_both(cyc, lcyc);
                check_value("data_done latency", mem_types_pkg::line_t'(cyc),
                            mem_types_pkg::line_t'(SINGLE_LAT));
                check_value("line_done latency", mem_types_pkg::line_t'(lcyc),
                            mem_types_pkg::line_t'(PAIR_LAT));
                check_value("data_rdata", mem_types_pkg::line_t'(data_rdata),
                            mem_types_pkg::line_t'(w0));
                check_value("line_rdata", line_rdata, ln);
                last_rd   = w0;
                last_line = ln;
            end
            default: report_failure("unknown op code in the test data file");
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_mask  = '0;
        data_wdata = '0;
        line_req   = 1'b0;
        line_we    = 1'b0;
        line_addr  = '0;
        line_wdata = '0;
        lfsr       = 32'hed5c0488;
        last_rd    = '0;  // router clears its read registers at reset
        last_line  = '0;
        rec        = 0;
        $readmemh("tests/simddr_testdata.txt", tdata);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_gap();
        // an ff op code ends the list
        while (rec < MAX_RECS && tdata[rec*REC_WORDS] !== 64'hff) begin
            run_record(rec * REC_WORDS);
            idle_gap();
            rec++;
        end
        if (rec == 0)
            report_failure("no records found in the test data file");
        $display("Finished with no errors");
        $finish;
    end
endmodule

// File: tests/simddr_testdata.txt
// op addr mask word0..word7 (hex); words are write data or expected read data
// op 0 single read, 1 single write, 2 burst read, 3 burst write, 4 data + line read together
1 010 ffffffffffffffff 0123456789abcdef 0 0 0 0 0 0 0
0 010 0 0123456789abcdef 0 0 0 0 0 0 0
1 010 ffff0000ffff0000 fedcba9876543210 0 0 0 0 0 0 0
0 010 0 fedc45677654cdef 0 0 0 0 0 0 0
3 020 0 a5a5a5a500000000
a5a5a5a500000001 a5a5a5a500000002 a5a5a5a500000003 a5a5a5a500000004
a5a5a5a500000005 a5a5a5a500000006 a5a5a5a500000007
2 020 0 a5a5a5a500000000
a5a5a5a500000001 a5a5a5a500000002 a5a5a5a500000003 a5a5a5a500000004
a5a5a5a500000005 a5a5a5a500000006 a5a5a5a500000007
0 020 0 a5a5a5a500000000 0 0 0 0 0 0 0
0 023 0 a5a5a5a500000003 0 0 0 0 0 0 0
0 027 0 a5a5a5a500000007 0 0 0 0 0 0 0
1 000 ffffffffffffffff 5a5a5a5a5a5a5a5a 0 0 0 0 0 0 0
1 3ff ffffffffffffffff c3c3c3c3c3c3c3c3 0 0 0 0 0 0 0
2 3ff 0 c3c3c3c3c3c3c3c3
5a5a5a5a5a5a5a5a 0 0 0
0 0 0
4 020 0 a5a5a5a500000000
a5a5a5a500000001 a5a5a5a500000002 a5a5a5a500000003 a5a5a5a500000004
a5a5a5a500000005 a5a5a5a500000006 a5a5a5a500000007
1 023 00000000ffffffff 0000000012345678 0 0 0 0 0 0 0
0 023 0 a5a5a5a512345678 0 0 0 0 0 0 0
ff

// File: verilog/ddr_ctrl_pkg.sv
// control encodings shared by arbiter, model and router
package ddr_ctrl_pkg;

    // which requester a command belongs to
    typedef enum logic {
        PORT_DATA,  // single word port
        PORT_LINE   // L2 / fetch burst port
    } port_id_e;

    // timing model FSM
    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } model_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_kind_e;

endpackage

// File: verilog/ddr_req_if.sv
`timescale 1ns/1ps

// one command from the arbiter, one completion from the model
interface ddr_req_if;
    logic                    cmd_valid;  // one-cycle strobe, only while model_idle
    ddr_ctrl_pkg::port_id_e  cmd_port;
    ddr_ctrl_pkg::op_kind_e  cmd_kind;
    logic                    cmd_burst;  // 1 = eight-word line access
    mem_types_pkg::addr_t    cmd_addr;
    mem_types_pkg::mask_t    cmd_mask;
    mem_types_pkg::word_t    cmd_wdata;
    mem_types_pkg::line_t    cmd_wline;
    logic                    model_idle;

    logic                    cpl_valid;  // one-cycle strobe with the cpl payload
    ddr_ctrl_pkg::port_id_e  cpl_port;
    ddr_ctrl_pkg::op_kind_e  cpl_kind;   // router needs it to keep read data on writes
    logic                    cpl_burst;
    mem_types_pkg::word_t    cpl_rdata;
    mem_types_pkg::line_t    cpl_rline;

    modport issuer (output cmd_valid, cmd_port, cmd_kind, cmd_burst,
                    output cmd_addr, cmd_mask, cmd_wdata, cmd_wline,
                    input  model_idle);
    modport model  (input  cmd_valid, cmd_port, cmd_kind, cmd_burst,
                    input  cmd_addr, cmd_mask, cmd_wdata, cmd_wline,
                    output model_idle,
                    output cpl_valid, cpl_port, cpl_kind, cpl_burst, cpl_rdata, cpl_rline);
    modport router (input  cpl_valid, cpl_port, cpl_kind, cpl_burst, cpl_rdata, cpl_rline);
endinterface

// File: verilog/ddr_timing_model.sv
`timescale 1ns/1ps
`include "simddr_params.svh"

module ddr_timing_model (
    input  logic     clk,
    input  logic     rst_n,
    ddr_req_if.model req
);
    ddr_ctrl_pkg::model_state_e  state;
    mem_types_pkg::cnt_t         cnt;        // cycles spent busy so far
    mem_types_pkg::cnt_t         cnt_last;   // final count of the held access
    logic                        fire;       // final busy cycle, access happens here
    ddr_ctrl_pkg::port_id_e      acc_port;
    ddr_ctrl_pkg::op_kind_e      acc_kind;
    logic                        acc_burst;
    mem_types_pkg::addr_t        acc_addr;
    mem_types_pkg::mask_t        acc_mask;
    mem_types_pkg::word_t        acc_wdata;
    mem_types_pkg::line_t        acc_wline;
    mem_types_pkg::line_t        rd_line;
    mem_types_pkg::word_t        mem [0:`DDR_DEPTH-1];

    // address of word k in a burst, wraps at the end of the array
    function automatic mem_types_pkg::addr_t burst_addr(mem_types_pkg::addr_t base, int k);
        return base + mem_types_pkg::addr_t'(k);
    endfunction

    initial begin
        for (int i = 0; i < `DDR_DEPTH; i++)
            mem[i] = '0;  // contents start cleared
    end

    assign cnt_last = acc_burst ? mem_types_pkg::cnt_t'(`DDR_BURST_CYCLES - 1)
                                : mem_types_pkg::cnt_t'(`DDR_SINGLE_CYCLES - 1);
    assign fire = (state == ddr_ctrl_pkg::ST_BUSY) && (cnt == cnt_last);
    assign req.model_idle = (state == ddr_ctrl_pkg::ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ddr_ctrl_pkg::ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ddr_ctrl_pkg::ST_IDLE: begin
                    if (req.cmd_valid) begin
                        state <= ddr_ctrl_pkg::ST_BUSY;  // idle drops next cycle
                        cnt   <= '0;
                    end
                end
                ddr_ctrl_pkg::ST_BUSY: begin
                    if (fire)
                        state <= ddr_ctrl_pkg::ST_IDLE;  // free again after completion
                    else
                        cnt <= cnt + mem_types_pkg::cnt_t'(1);
                end
                default: state <= ddr_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    // command held for the whole busy period
    always_ff @(posedge clk) begin
        if (req.model_idle && req.cmd_valid) begin
            acc_port  <= req.cmd_port;
            acc_kind  <= req.cmd_kind;
            acc_burst <= req.cmd_burst;
            acc_addr  <= req.cmd_addr;
            acc_mask  <= req.cmd_mask;
            acc_wdata <= req.cmd_wdata;
            acc_wline <= req.cmd_wline;
        end
    end

    // array update at the end of the final busy cycle
    always_ff @(posedge clk) begin
        if (fire && acc_kind == ddr_ctrl_pkg::OP_WRITE) begin
            if (acc_burst) begin
                for (int k = 0; k < `DDR_BURST_WORDS; k++)
                    mem[burst_addr(acc_addr, k)] <= acc_wline[k*`DDR_WORD_BITS +: `DDR_WORD_BITS];
            end else begin
                // masked merge, clear mask bits keep the stored value
                mem[acc_addr] <= (mem[acc_addr] & ~acc_mask) | (acc_wdata & acc_mask);
            end
        end
    end

    always_comb begin
        rd_line = '0;
        for (int k = 0; k < `DDR_BURST_WORDS; k++)
            rd_line[k*`DDR_WORD_BITS +: `DDR_WORD_BITS] = mem[burst_addr(acc_addr, k)];
    end

    // completion presented in the final cycle, before the write lands
    assign req.cpl_valid = fire;
    assign req.cpl_port  = acc_port;
    assign req.cpl_kind  = acc_kind;
    assign req.cpl_burst = acc_burst;
    assign req.cpl_rdata = mem[acc_addr];
    assign req.cpl_rline = rd_line;
endmodule

// File: verilog/mem_types_pkg.sv
`include "simddr_params.svh"

// vector types of the data path
package mem_types_pkg;

    // word address into the model array
    typedef logic [`DDR_ADDR_BITS-1:0] addr_t;

    // single data word
    typedef logic [`DDR_WORD_BITS-1:0] word_t;

    // per-bit write mask, set bit = bit gets written
    typedef logic [`DDR_WORD_BITS-1:0] mask_t;

    // burst line, word k at bits 64k and up
    typedef logic [`DDR_BURST_WORDS*`DDR_WORD_BITS-1:0] line_t;

    // latency counter, wide enough for the burst latency
    typedef logic [7:0] cnt_t;

endpackage

// File: verilog/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  data_req,    // one-cycle strobe from the data port
    input  logic                  data_we,
    input  mem_types_pkg::addr_t  data_addr,
    input  mem_types_pkg::mask_t  data_mask,
    input  mem_types_pkg::word_t  data_wdata,
    input  logic                  line_req,    // one-cycle strobe from the line port
    input  logic                  line_we,
    input  mem_types_pkg::addr_t  line_addr,
    input  mem_types_pkg::line_t  line_wdata,
    ddr_req_if.issuer             req
);
    logic                  pend_data;   // data port request waiting for the model
    logic                  pend_line;
    logic                  take_data;   // strobe accepted into the pending slot
    logic                  take_line;
    logic                  issue_data;
    logic                  issue_line;
    logic                  data_we_q;
    mem_types_pkg::addr_t  data_addr_q;
    mem_types_pkg::mask_t  data_mask_q;
    mem_types_pkg::word_t  data_wdata_q;
    logic                  line_we_q;
    mem_types_pkg::addr_t  line_addr_q;
    mem_types_pkg::line_t  line_wdata_q;

    // a strobe on an occupied slot breaks the protocol and is dropped
    assign take_data = data_req && !pend_data;
    assign take_line = line_req && !pend_line;

    // fixed priority, data port wins when both wait
    assign issue_data = req.model_idle && pend_data;
    assign issue_line = req.model_idle && pend_line && !pend_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_data <= 1'b0;
            pend_line <= 1'b0;
        end else begin
            if (take_data)
                pend_data <= 1'b1;
            else if (issue_data)
                pend_data <= 1'b0;  // handed to the model
            if (take_line)
                pend_line <= 1'b1;
            else if (issue_line)
                pend_line <= 1'b0;
        end
    end

    // request payload, captured at the strobe
    always_ff @(posedge clk) begin
        if (take_data) begin
            data_we_q    <= data_we;
            data_addr_q  <= data_addr;
            data_mask_q  <= data_mask;
            data_wdata_q <= data_wdata;
        end
        if (take_line) begin
            line_we_q    <= line_we;
            line_addr_q  <= line_addr;
            line_wdata_q <= line_wdata;
        end
    end

    assign req.cmd_valid = issue_data || issue_line;
    assign req.cmd_port  = pend_data ? ddr_ctrl_pkg::PORT_DATA : ddr_ctrl_pkg::PORT_LINE;
    assign req.cmd_burst = !pend_data;   // line port always moves eight words
    assign req.cmd_kind  = (pend_data ? data_we_q : line_we_q) ? ddr_ctrl_pkg::OP_WRITE
                                                               : ddr_ctrl_pkg::OP_READ;
    assign req.cmd_addr  = pend_data ? data_addr_q : line_addr_q;
    assign req.cmd_mask  = data_mask_q;  // only looked at on single writes
    assign req.cmd_wdata = data_wdata_q;
    assign req.cmd_wline = line_wdata_q;
endmodule

// File: verilog/resp_router.sv
`timescale 1ns/1ps

module resp_router (
    input  logic                  clk,
    input  logic                  rst_n,
    ddr_req_if.router             req,
    output logic                  data_done,   // one-cycle strobe per data port access
    output mem_types_pkg::word_t  data_rdata,  // held until the next data port read
    output logic                  line_done,
    output mem_types_pkg::line_t  line_rdata
);
    logic cpl_data;   // completion belongs to the data port
    logic cpl_line;
    logic cpl_read;

    assign cpl_data = req.cpl_valid && (req.cpl_port == ddr_ctrl_pkg::PORT_DATA);
    assign cpl_line = req.cpl_valid && (req.cpl_port == ddr_ctrl_pkg::PORT_LINE);
    assign cpl_read = req.cpl_valid && (req.cpl_kind == ddr_ctrl_pkg::OP_READ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_done <= 1'b0;
            line_done <= 1'b0;
        end else begin
            data_done <= cpl_data;  // drops again next cycle
            line_done <= cpl_line;
        end
    end

    // read data registers, writes leave them alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_rdata <= '0;
            line_rdata <= '0;
        end else if (cpl_read) begin
            if (req.cpl_burst)
                line_rdata <= req.cpl_rline;  // full eight-word line
            else
                data_rdata <= req.cpl_rdata;
        end
    end
endmodule

// File: verilog/simddr_params.svh
`ifndef SIMDDR_PARAMS_SVH
`define SIMDDR_PARAMS_SVH

// word address width, 2^10 words in the model
`define DDR_ADDR_BITS 10

// one data word
`define DDR_WORD_BITS 64

// consecutive words moved by one burst
`define DDR_BURST_WORDS 8

// fixed access latencies in clock cycles
`define DDR_SINGLE_CYCLES 64
`define DDR_BURST_CYCLES 80

// array depth follows the address width
`define DDR_DEPTH (1 << `DDR_ADDR_BITS)

`endif

// File: verilog/simddr_top.sv
`timescale 1ns/1ps

module simddr_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // data port, single masked accesses
    input  logic                  data_req,
    input  logic                  data_we,
    input  mem_types_pkg::addr_t  data_addr,
    input  mem_types_pkg::mask_t  data_mask,
    input  mem_types_pkg::word_t  data_wdata,
    output logic                  data_done,
    output mem_types_pkg::word_t  data_rdata,
    // line port, eight-word bursts for L2 and fetch
    input  logic                  line_req,
    input  logic                  line_we,
    input  mem_types_pkg::addr_t  line_addr,
    input  mem_types_pkg::line_t  line_wdata,
    output logic                  line_done,
    output mem_types_pkg::line_t  line_rdata
);
    ddr_req_if i_bus ();  // command and completion between the three blocks

    port_arbiter i_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_mask  (data_mask),
        .data_wdata (data_wdata),
        .line_req   (line_req),
        .line_we    (line_we),
        .line_addr  (line_addr),
        .line_wdata (line_wdata),
        .req        (i_bus.issuer)
    );

    // array plus fixed latency
    ddr_timing_model i_model (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (i_bus.model)
    );

    resp_router i_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (i_bus.router),
        .data_done  (data_done),
        .data_rdata (data_rdata),
        .line_done  (line_done),
        .line_rdata (line_rdata)
    );
endmodule
